//--- src.f
logic/capture_pkg.sv
logic/cmd_frame_parser.sv
logic/channel_sampler.sv
logic/upload_framer.sv
logic/logic_capture_top.sv
testbench/logic_capture_asserts.sv
testbench/logic_capture_tb.sv

//--- testbench/logic_capture_tb.sv
/*
 * Testbench for the logic analyser core
 *   Clock, reset, LFSR stimulus and command frame tasks
 *   Tx pair model, per-test results and a cycle limit
 */

`timescale 1ns/1ns

module logic_capture_tb;

    import capture_pkg::*;

    // Per-test cycle budgets, plus a fifth
    localparam int budget      = 80 + 60 + 160 + 120 + 160 + 90;
    localparam int cycle_limit = budget + budget / 5;

    logic        clk;
    logic        rst_n;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic [7:0]  dc_signal_in;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        capture_active;
    logic        cmd_ready;

    int          cyc = 0;               // Rising edges so far
    logic [15:0] lfsr_state = 16'd49;
    logic [7:0]  dc_hist [0:1023];      // Channels as sampled on each edge
    int          src_q [$];             // Edges where a source byte was seen
    logic        data_due = 1'b0;
    int          check_errors = 0;
    int          tests_failed = 0;
    int          hdr_cyc;               // Edge of the low length byte
    int          last_cyc;              // Edge of the last byte sent
    int          exp_div;
    int          fresh_after;           // Older sources may still drain
    int          first_src;
    int          next_tick = 0;
    int          tick_div = 0;

    logic_capture_top logic_capture_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .dc_signal_in   (dc_signal_in),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .capture_active (capture_active),
        .cmd_ready      (cmd_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = 8'd0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    function automatic int error_total();
        return check_errors + logic_capture_top_i.logic_capture_asserts_i.assert_errors;
    endfunction

    // ========================================================================
    // Tx monitor, one source byte then one data byte
    // ========================================================================
    always @(posedge clk) begin
        cyc = cyc + 1;
        dc_hist[cyc % 1024] = dc_signal_in;
        if (data_due) begin
            data_due = 1'b0;
            if (!tx_valid) begin
                $display("Data byte missing after the source byte at %0t", $time);
                check_errors++;
            end else if (tx_data !== dc_hist[(cyc - 3) % 1024]) begin
                $display("Mismatch at time %0t: data byte %h, channels were %h",
                         $time, tx_data, dc_hist[(cyc - 3) % 1024]);
                check_errors++;
            end
        end else if (tx_valid) begin
            src_q.push_back(cyc);
            data_due = 1'b1;
            if (tx_data !== upload_source_dc) begin
                $display("Mismatch at time %0t: source byte %h", $time, tx_data);
                check_errors++;
            end
        end
    end

    // New channel pattern right after each expected tick
    initial begin
        logic [7:0] v;
        forever begin
            @(negedge clk);
            if ((tick_div != 0) && (cyc == next_tick)) begin
                take_bits(8, v);
                dc_signal_in = v;
                next_tick    = next_tick + tick_div;
            end
        end
    end

    initial begin
        wait (cyc >= cycle_limit);
        $display("Run stopped by the cycle limit at edge %0d", cyc);
        $display("TEST FAILED");
        $finish;
    end

    // ========================================================================
    // Frame tasks, called on a falling edge
    // ========================================================================
    task automatic send_byte(input logic [7:0] b);
        logic [7:0] gap;
        take_bits(2, gap);
        repeat (gap) @(negedge clk);        // 0 to 3 idle cycles
        rx_data  = b;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        last_cyc = cyc;
    endtask

    task automatic send_frame(input logic [7:0] ftype, input logic [15:0] len,
                              input logic [7:0] p0, input logic [7:0] p1,
                              input logic [7:0] p2);
        send_byte(frame_sync);
        send_byte(ftype);
        send_byte(len[15:8]);
        send_byte(len[7:0]);
        hdr_cyc = last_cyc;
        if (len > 0) send_byte(p0);
        if (len > 1) send_byte(p1);
        if (len > 2) send_byte(p2);
    endtask

    task automatic start_capture(input logic [7:0] hi, input logic [7:0] lo,
                                 input logic [15:0] len);
        send_frame(cmd_dc_start, len, hi, lo, 8'h01);
        exp_div     = ({hi, lo} < 16'd2) ? 2 : {hi, lo};
        fresh_after = hdr_cyc + 2;
        first_src   = last_cyc + exp_div + 3;
        next_tick   = last_cyc + 1;         // Ticks realign to the frame end
        tick_div    = exp_div;
    endtask

    function automatic int count_after(input int after);
        int n;
        n = 0;
        foreach (src_q[i]) begin
            if (src_q[i] > after) n++;
        end
        return n;
    endfunction

    // Wait for n pairs, then check first arrival and spacing
    task automatic check_pairs(input int after, input int first, input int n);
        int prev;
        while (count_after(after) < n) @(negedge clk);
        prev = 0;
        foreach (src_q[i]) begin
            if (src_q[i] > after) begin
                if ((prev == 0) && (src_q[i] != first)) begin
                    $display("Mismatch at time %0t: first source at edge %0d, expected %0d",
                             $time, src_q[i], first);
                    check_errors++;
                end else if ((prev != 0) && (src_q[i] - prev != exp_div)) begin
                    $display("Mismatch at time %0t: pair spacing %0d, expected %0d",
                             $time, src_q[i] - prev, exp_div);
                    check_errors++;
                end
                prev = src_q[i];
            end
        end
    endtask

    task automatic test_done(input string name, input int errs_before);
        if (error_total() == errs_before) begin
            $display("%-26s ok", name);
        end else begin
            tests_failed++;
            $display("%-26s failed, %0d errors", name, error_total() - errs_before);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        int errs;
        int keep_after;
        int keep_first;
        rst_n        = 1'b0;
        rx_data      = 8'h00;
        rx_valid     = 1'b0;
        dc_signal_in = 8'h00;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs = error_total();
        start_capture(8'h00, 8'h05, 16'd2);
        check_pairs(fresh_after, first_src, 4);
        test_done("start, divider 5", errs);

        errs = error_total();
        send_frame(cmd_dc_stop, 16'd0, 8'h00, 8'h00, 8'h00);
        tick_div = 0;
        repeat (20) @(negedge clk);
        if (count_after(hdr_cyc + 2) != 0) begin
            $display("Source byte sent after STOP took effect");
            check_errors++;
        end
        if ((capture_active !== 1'b0) || (cmd_ready !== 1'b1)) begin
            $display("Mismatch at time %0t: capture_active %b, cmd_ready %b after STOP",
                     $time, capture_active, cmd_ready);
            check_errors++;
        end
        test_done("stop", errs);

        errs = error_total();
        start_capture(8'h00, 8'h05, 16'd2);
        check_pairs(fresh_after, first_src, 2);
        start_capture(8'h00, 8'h09, 16'd2);  // Restart while capturing
        check_pairs(fresh_after, first_src, 4);
        test_done("restart, divider 9", errs);

        errs = error_total();
        start_capture(8'h00, 8'h00, 16'd2);
        check_pairs(fresh_after, first_src, 4);
        start_capture(8'h00, 8'h01, 16'd2);
        check_pairs(fresh_after, first_src, 4);
        test_done("divider 0 and 1", errs);

        // Noise and an unknown frame must not disturb the running capture
        errs = error_total();
        start_capture(8'h00, 8'h07, 16'd2);
        keep_after = fresh_after;
        keep_first = first_src;
        check_pairs(keep_after, keep_first, 2);
        send_byte(8'h3C);
        send_byte(8'hFF);
        send_byte(8'h00);
        send_frame(8'h55, 16'd2, 8'h00, 8'h03, 8'h00);
        check_pairs(keep_after, keep_first, 8);
        test_done("noise and unknown type", errs);

        errs = error_total();
        start_capture(8'h00, 8'h06, 16'd3);  // Third byte ignored
        check_pairs(fresh_after, first_src, 3);
        send_frame(cmd_dc_stop, 16'd0, 8'h00, 8'h00, 8'h00);
        tick_div = 0;
        repeat (10) @(negedge clk);
        test_done("start with 3 byte payload", errs);

        $display("Tests: 6, failed: %0d, check errors: %0d, assertion errors: %0d",
                 tests_failed, check_errors,
                 logic_capture_top_i.logic_capture_asserts_i.assert_errors);
        if ((tests_failed == 0) && (error_total() == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/logic_capture_asserts.sv
/*
 * Concurrent checks on the logic analyser top level
 *   Quiet tx before START, source and data pairing, upload spacing,
 *   status level consistency; bound to logic_capture_top
 */

`timescale 1ns/1ns

module logic_capture_asserts (
    input logic clk,
    input logic rst_n,
    input logic tx_valid,
    input logic upload_valid,       // Sampler to framer strobe inside the top
    input logic capture_active,
    input logic cmd_ready
);

    int         assert_errors = 0;  // Read by the testbench
    logic       start_seen;         // Capture has run at least once
    logic       data_due;           // Next tx byte is the sample
    logic       src_byte;

    assign src_byte = tx_valid && !data_due;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_seen <= 1'b0;
            data_due   <= 1'b0;
        end else begin
            if (capture_active) start_seen <= 1'b1;
            data_due <= src_byte;
        end
    end

    // ========================================================================
    // Properties
    // ========================================================================
    tx_quiet_before_start: assert property (
        @(posedge clk) disable iff (!rst_n) !start_seen |-> !tx_valid
    ) else begin
        assert_errors++;
        $error("tx byte sent before any START was accepted");
    end

    pair_complete: assert property (
        @(posedge clk) disable iff (!rst_n) src_byte |=> tx_valid
    ) else begin
        assert_errors++;
        $error("Source byte not followed by a data byte");
    end

    // Each upload starts a source byte one cycle later
    pair_spacing: assert property (
        @(posedge clk) disable iff (!rst_n) upload_valid |=> !upload_valid
    ) else begin
        assert_errors++;
        $error("Sample uploads on consecutive cycles, source bytes would overlap");
    end

    status_levels: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_ready |-> !capture_active
    ) else begin
        assert_errors++;
        $error("capture_active high while cmd_ready is high");
    end

endmodule

bind logic_capture_top logic_capture_asserts logic_capture_asserts_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .tx_valid       (tx_valid),
    .upload_valid   (upload_valid),
    .capture_active (capture_active),
    .cmd_ready      (cmd_ready)
);

//--- logic/logic_capture_top.sv
/*
 * Logic analyser core top level
 *   Frame parser, channel sampler and upload framer
 *   with the capture status levels brought out
 */

`timescale 1ns/1ns

module logic_capture_top (
    input  logic       clk,
    input  logic       rst_n,

    // Host link bytes in
    input  logic [7:0] rx_data,
    input  logic       rx_valid,

    // Eight channels under test
    input  logic [7:0] dc_signal_in,

    // Host link bytes out
    output logic [7:0] tx_data,
    output logic       tx_valid,

    // Status
    output logic       capture_active,
    output logic       cmd_ready
);

    // ========================================================================
    // Parser to sampler
    // ========================================================================
    logic [7:0]  cmd_type;
    logic [15:0] cmd_length;
    logic        cmd_start;
    logic [7:0]  cmd_data;
    logic [15:0] cmd_data_index;
    logic        cmd_data_valid;
    logic        cmd_done;

    // Sampler to framer
    logic [7:0]  upload_data;
    logic        upload_valid;

    cmd_frame_parser cmd_frame_parser_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .cmd_type       (cmd_type),
        .cmd_length     (cmd_length),
        .cmd_start      (cmd_start),
        .cmd_data       (cmd_data),
        .cmd_data_index (cmd_data_index),
        .cmd_data_valid (cmd_data_valid),
        .cmd_done       (cmd_done)
    );

    channel_sampler channel_sampler_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_type       (cmd_type),
        .cmd_length     (cmd_length),
        .cmd_start      (cmd_start),
        .cmd_data       (cmd_data),
        .cmd_data_index (cmd_data_index),
        .cmd_data_valid (cmd_data_valid),
        .cmd_done       (cmd_done),
        .cmd_ready      (cmd_ready),
        .dc_signal_in   (dc_signal_in),
        .capture_active (capture_active),
        .upload_data    (upload_data),
        .upload_valid   (upload_valid)
    );

    // Two tx bytes per sample
    upload_framer upload_framer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .upload_valid   (upload_valid),
        .upload_data    (upload_data),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid)
    );

endmodule

//--- logic/upload_framer.sv
/*
 * Upload framer
 *   Sends the source identifier and then the held sample
 *   on two consecutive cycles of the outgoing byte stream
 */

`timescale 1ns/1ns

module upload_framer (
    input  logic       clk,
    input  logic       rst_n,

    // Sample from the sampler
    input  logic       upload_valid,
    input  logic [7:0] upload_data,

    // Outgoing byte stream
    output logic [7:0] tx_data,
    output logic       tx_valid
);

    import capture_pkg::*;

    logic [7:0] sample_hold;    // Sample waiting for its slot
    logic       data_phase;     // High while the data byte is due

    // ========================================================================
    // Phase and strobe control
    // ========================================================================
    // Divider of at least 2 keeps a new upload off the data phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_phase <= 1'b0;
            tx_valid   <= 1'b0;
        end else begin
            if (data_phase) begin
                data_phase <= 1'b0;   // Second byte of the pair
                tx_valid   <= 1'b1;
            end else if (upload_valid) begin
                data_phase <= 1'b1;   // Source byte goes out first
                tx_valid   <= 1'b1;
            end else begin
                tx_valid   <= 1'b0;
            end
        end
    end

    // ========================================================================
    // Byte registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (upload_valid) sample_hold <= upload_data;
    end

    always_ff @(posedge clk) begin
        if (data_phase) begin
            tx_data <= sample_hold;         // Sample byte
        end else if (upload_valid) begin
            tx_data <= upload_source_dc;    // Source tag
        end
    end

endmodule

//--- logic/channel_sampler.sv
/*
 * Channel sampler
 *   Command FSM for START and STOP frames
 *   Divider collection and sample tick counter
 *   Registers the eight channels on each tick and uploads them
 */

`timescale 1ns/1ns

module channel_sampler (
    input  logic        clk,
    input  logic        rst_n,

    // Command side from the parser
    input  logic [7:0]  cmd_type,
    input  logic [15:0] cmd_length,
    input  logic        cmd_start,
    input  logic [7:0]  cmd_data,
    input  logic [15:0] cmd_data_index,
    input  logic        cmd_data_valid,
    input  logic        cmd_done,
    output logic        cmd_ready,

    // Channel inputs
    input  logic [7:0]  dc_signal_in,

    // Sample upload
    output logic        capture_active,
    output logic [7:0]  upload_data,
    output logic        upload_valid
);

    import capture_pkg::*;

    logic [1:0]  state;
    split_word_u div_acc;       // Divider bytes received so far
    split_word_u div_next;      // Including the byte on cmd_data now
    logic [15:0] div_applied;   // Clamped to divider_min
    logic [15:0] sample_div;    // Divider in effect
    logic [15:0] sample_cnt;
    logic        sample_tick;
    logic        start_cmd;
    logic        stop_cmd;
    logic        byte_ok;

    // ========================================================================
    // Command decode
    // ========================================================================
    assign start_cmd = cmd_start && (cmd_type == cmd_dc_start);
    assign stop_cmd  = cmd_start && (cmd_type == cmd_dc_stop);

    // Payload byte inside the announced length
    assign byte_ok = cmd_data_valid && (cmd_data_index < cmd_length);

    // Merge in index 0 and 1 only, later bytes dropped
    always_comb begin
        div_next = div_acc;
        if (byte_ok && (cmd_data_index == 16'd0)) div_next.part.hi = cmd_data;
        if (byte_ok && (cmd_data_index == 16'd1)) div_next.part.lo = cmd_data;
    end

    assign div_applied = (div_next.value < divider_min) ? divider_min : div_next.value;

    // Status levels
    assign capture_active = (state == s_capturing);
    assign cmd_ready      = (state != s_capturing);

    // ========================================================================
    // Command state machine
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= s_idle;
            sample_div <= divider_reset_value;
        end else begin
            case (state)
                s_idle: begin
                    if (start_cmd) state <= s_receiving;  // STOP here is a no-op
                end
                s_receiving: begin
                    if (cmd_done) begin
                        sample_div <= div_applied;     // Final byte merged in
                        state      <= s_capturing;
                    end
                end
                s_capturing: begin
                    if (stop_cmd) state <= s_idle;
                    else if (start_cmd) state <= s_receiving;  // New rate
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Divider bytes, cleared by each START header
    always_ff @(posedge clk) begin
        if (start_cmd) begin
            div_acc.value <= 16'd0;
        end else if ((state == s_receiving) && byte_ok) begin
            div_acc <= div_next;
        end
    end

    // ========================================================================
    // Sample tick generation
    // ========================================================================
    // Tick every sample_div cycles, counted from the cmd_done cycle
    // A START or STOP header blocks the tick in its own cycle
    assign sample_tick = capture_active && !start_cmd && !stop_cmd &&
                         (sample_cnt >= sample_div - 16'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt <= 16'd0;
        end else if (!capture_active || sample_tick) begin
            sample_cnt <= 16'd0;     // Held at zero outside capture
        end else begin
            sample_cnt <= sample_cnt + 16'd1;
        end
    end

    // ========================================================================
    // Channel capture and upload
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upload_valid <= 1'b0;
        end else begin
            upload_valid <= sample_tick;   // One cycle behind the tick
        end
    end

    // Value on the tick itself, bit n is channel n
    always_ff @(posedge clk) begin
        if (sample_tick) upload_data <= dc_signal_in;
    end

endmodule

//--- logic/cmd_frame_parser.sv
/*
 * Command frame parser
 *   Hunts for the sync byte, then takes type and big-endian length
 *   Strobes each payload byte out with its index
 *   Pulses cmd_start after the header and cmd_done at the frame end
 */

`timescale 1ns/1ns

module cmd_frame_parser (
    input  logic        clk,
    input  logic        rst_n,

    // Host byte stream
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,

    // Decoded command
    output logic [7:0]  cmd_type,
    output logic [15:0] cmd_length,
    output logic        cmd_start,
    output logic [7:0]  cmd_data,
    output logic [15:0] cmd_data_index,
    output logic        cmd_data_valid,
    output logic        cmd_done
);

    import capture_pkg::*;

    logic [2:0]  state;
    logic [7:0]  type_acc;      // Type byte of the frame in flight
    split_word_u len_acc;       // Length built a byte at a time
    logic [15:0] payload_cnt;   // Payload bytes seen so far
    logic        last_byte;

    // Byte that closes a non-empty payload
    assign last_byte = (payload_cnt == len_acc.value - 16'd1);

    // ========================================================================
    // Frame state machine
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= p_hunt;
            cmd_start      <= 1'b0;
            cmd_data_valid <= 1'b0;
            cmd_done       <= 1'b0;
            payload_cnt    <= 16'd0;
        end else begin
            cmd_start      <= 1'b0;   // All strobes one cycle wide
            cmd_data_valid <= 1'b0;
            cmd_done       <= 1'b0;
            case (state)
                p_hunt: begin
                    if (rx_valid && (rx_data == frame_sync)) begin
                        state <= p_type;  // Anything else is noise
                    end
                end
                p_type: begin
                    if (rx_valid) state <= p_len_hi;
                end
                p_len_hi: begin
                    if (rx_valid) state <= p_len_lo;
                end
                p_len_lo: begin
                    if (rx_valid) begin
                        cmd_start   <= 1'b1;      // Header complete
                        payload_cnt <= 16'd0;
                        state       <= p_payload;
                    end
                end
                p_payload: begin
                    if (len_acc.value == 16'd0) begin
                        // Empty frame ends right after cmd_start
                        cmd_done <= 1'b1;
                        if (rx_valid && (rx_data == frame_sync)) state <= p_type;
                        else state <= p_hunt;
                    end else if (rx_valid) begin
                        cmd_data_valid <= 1'b1;
                        payload_cnt    <= payload_cnt + 16'd1;
                        if (last_byte) begin
                            cmd_done <= 1'b1;     // Same cycle as final byte
                            state    <= p_hunt;
                        end
                    end
                end
                default: state <= p_hunt;
            endcase
        end
    end

    // ========================================================================
    // Header and payload registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (state == p_type) type_acc <= rx_data;
            if (state == p_len_hi) len_acc.part.hi <= rx_data;
            if (state == p_len_lo) begin
                len_acc.part.lo <= rx_data;
                // Outputs held until the next header
                cmd_type   <= type_acc;
                cmd_length <= {len_acc.part.hi, rx_data};
            end
            if ((state == p_payload) && (len_acc.value != 16'd0)) begin
                cmd_data       <= rx_data;
                cmd_data_index <= payload_cnt;
            end
        end
    end

endmodule

//--- logic/capture_pkg.sv
/*
 * Shared definitions for the logic analyser core
 *   Frame sync byte, command codes and upload source identifier
 *   Divider reset value and lower limit
 *   Parser and sampler state encodings
 *   Split 16-bit word union
 */

package capture_pkg;

    // ========================================================================
    // Frame and command codes
    // ========================================================================
    localparam logic [7:0]  frame_sync          = 8'hA5;  // First byte of every frame
    localparam logic [7:0]  cmd_dc_start        = 8'h0B;  // Start or restart capture
    localparam logic [7:0]  cmd_dc_stop         = 8'h0C;  // End capture
    localparam logic [7:0]  upload_source_dc    = 8'h0B;  // Tag ahead of each sample

    // Sampling divider limits
    localparam logic [15:0] divider_reset_value = 16'd60; // Rate out of reset
    localparam logic [15:0] divider_min         = 16'd2;  // Keeps tx pairs apart

    // ========================================================================
    // State encodings
    // ========================================================================
    // Frame parser
    localparam logic [2:0]  p_hunt              = 3'd0;   // Waiting for sync
    localparam logic [2:0]  p_type              = 3'd1;
    localparam logic [2:0]  p_len_hi            = 3'd2;
    localparam logic [2:0]  p_len_lo            = 3'd3;
    localparam logic [2:0]  p_payload           = 3'd4;

    // Channel sampler
    localparam logic [1:0]  s_idle              = 2'd0;
    localparam logic [1:0]  s_receiving         = 2'd1;   // Collecting divider bytes
    localparam logic [1:0]  s_capturing         = 2'd2;

    // 16-bit word seen whole or as two bytes, big-endian order
    typedef union packed {
        logic [15:0] value;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } part;
    } split_word_u;

endpackage
